// File: Bender.yml
package:
  name: commit_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/commit_pkg.sv
      - verilog/commit_buffer.sv
      - verilog/commit_arbiter.sv
      - verilog/commit_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/commit_checker.sv
      - tb/tb_commit_stage.sv

// File: commit_stage.f
+incdir+verilog
verilog/commit_pkg.sv
verilog/commit_buffer.sv
verilog/commit_arbiter.sv
verilog/commit_stage.sv
tb/commit_checker.sv
tb/tb_commit_stage.sv

// File: tb/commit_checker.sv
// Commit stage scoreboard that checks reorder buffer writes and status flags
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commit_checker (
    input  wire logic                                          clk_i,
    input  wire logic                                          rst_n_i,
    input  wire logic                                          flush_i,
    input  wire logic                                          stall_i,
    input  wire logic                                          dut_stall_i,
    input  wire logic                    [`COMMIT_LANES-1:0]   data_valid_i,
    input  wire commit_pkg::instr_packet_t [`COMMIT_LANES-1:0] ipacket_i,
    input  wire commit_pkg::rob_entry_t  [`COMMIT_LANES-1:0]   exp_entry_i,
    input  wire logic                                          rob_write_i,
    input  wire logic                    [`COMMIT_TAG_W-1:0]   rob_tag_i,
    input  wire commit_pkg::rob_entry_t                        rob_entry_i,
    input  wire logic                                          buffers_empty_i,
    output      int unsigned                                   error_count_o,
    output      int unsigned                                   outstanding_o
);

    localparam int unsigned TAGS = 1 << `COMMIT_TAG_W;

    // Scoreboard indexed by reorder buffer tag
    logic                   pending  [TAGS];
    commit_pkg::rob_entry_t expected [TAGS];
    int unsigned            lane_of  [TAGS];
    int unsigned            seq_of   [TAGS];

    // Arrivals minus departures per lane is what a buffer holds
    int unsigned            next_in  [`COMMIT_LANES];
    int unsigned            next_out [`COMMIT_LANES];
    int unsigned            errors = 0;

    // ============================================================
    // Sampling at the rising edge, all inputs are settled here
    // ============================================================

    always @(posedge clk_i) begin : check_edge
        logic                     exp_stall;
        logic                     exp_empty;
        logic [`COMMIT_TAG_W-1:0] tag;
        int unsigned              lane;
        int unsigned              held;

        if (!rst_n_i) begin
            for (int t = 0; t < TAGS; t++) begin
                pending[t] = 1'b0;
            end
            for (int l = 0; l < `COMMIT_LANES; l++) begin
                next_in[l]  = 0;
                next_out[l] = 0;
            end
        end else begin
            // Status flags follow the occupancy left by the previous edge
            exp_stall = 1'b0;
            exp_empty = 1'b1;
            for (int l = 0; l < `COMMIT_LANES; l++) begin
                if (next_in[l] - next_out[l] >= `COMMIT_BUF_DEPTH) begin
                    exp_stall = 1'b1;
                end
                if (next_in[l] != next_out[l]) begin
                    exp_empty = 1'b0;
                end
            end
            if (dut_stall_i !== exp_stall) begin
                errors++;
                $display("ERR stall_o got %h expected %h", dut_stall_i, exp_stall);
            end
            if (buffers_empty_i !== exp_empty) begin
                errors++;
                $display("ERR buffers_empty_o got %h expected %h", buffers_empty_i, exp_empty);
            end
            // With nothing buffered a fresh result has to go straight through
            if (exp_empty && !stall_i && !flush_i && (data_valid_i != '0) && rob_write_i !== 1'b1) begin
                errors++;
                $display("ERR rob_write_o got %h expected %h", rob_write_i, 1'b1);
            end

            // Record this cycle's accepted results before the write, so a bypass matches
            if (!flush_i) begin
                for (int l = 0; l < `COMMIT_LANES; l++) begin
                    if (data_valid_i[l]) begin
                        tag = ipacket_i[l].rob_tag;
                        if (pending[tag]) begin
                            errors++;
                            $display("Tag %h was presented again while still outstanding", tag);
                        end
                        pending[tag]  = 1'b1;
                        expected[tag] = exp_entry_i[l];
                        lane_of[tag]  = l;
                        seq_of[tag]   = next_in[l];
                        next_in[l]++;
                    end
                end
            end

            if (rob_write_i) begin
                if (stall_i) begin
                    errors++;
                    $display("Reorder buffer was written while stall_i was high");
                end
                if (!pending[rob_tag_i]) begin
                    errors++;
                    $display("Tag %h was written but is not outstanding (duplicate or unknown)",
                             rob_tag_i);
                end else begin
                    lane = lane_of[rob_tag_i];
                    // Each lane must leave in the order it arrived
                    if (seq_of[rob_tag_i] != next_out[lane]) begin
                        errors++;
                        $display("ERR rob_tag_o lane %0d order got seq %h expected seq %h",
                                 lane, seq_of[rob_tag_i], next_out[lane]);
                    end
                    if (rob_entry_i !== expected[rob_tag_i]) begin
                        errors++;
                        $display("ERR rob_entry_o tag %h got %h expected %h",
                                 rob_tag_i, rob_entry_i, expected[rob_tag_i]);
                    end
                    pending[rob_tag_i] = 1'b0;
                    next_out[lane]++;
                end
            end

            // A flush throws away everything still buffered
            if (flush_i) begin
                for (int t = 0; t < TAGS; t++) begin
                    pending[t] = 1'b0;
                end
                for (int l = 0; l < `COMMIT_LANES; l++) begin
                    next_out[l] = next_in[l];
                end
            end
        end

        held = 0;
        for (int l = 0; l < `COMMIT_LANES; l++) begin
            held += next_in[l] - next_out[l];
        end
        outstanding_o <= held;
        error_count_o <= errors;
    end

endmodule : commit_checker

`default_nettype wire

// File: tb/tb_commit_stage.sv
// Commit stage testbench with directed phases, then random traffic with stalls and flushes
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module tb_commit_stage;

    localparam int unsigned RESET_CYCLES  = 10;
    localparam int unsigned RANDOM_CYCLES = 3000;
    localparam int unsigned DRAIN_TIMEOUT = 100;

    logic                                          clk;
    logic                                          rst_n;
    logic                                          flush;
    logic                                          stall_in;
    logic                                          stall_out;
    logic                      [`COMMIT_LANES-1:0] want_valid;
    logic                      [`COMMIT_LANES-1:0] data_valid;
    commit_pkg::instr_packet_t [`COMMIT_LANES-1:0] ipacket;
    commit_pkg::data_word_t    [`COMMIT_LANES-1:0] result;
    commit_pkg::rob_entry_t    [`COMMIT_LANES-1:0] exp_entry;
    logic                                          rob_write;
    logic                      [`COMMIT_TAG_W-1:0] rob_tag;
    commit_pkg::rob_entry_t                        rob_entry;
    logic                                          buffers_empty;
    logic [31:0]              rng;
    logic [`COMMIT_TAG_W-1:0] next_tag;
    int unsigned              stall_left;
    int unsigned              tb_errors;
    int unsigned              check_errors;
    int unsigned              outstanding;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // The reorder buffer keeps result, destination and exception info but not the tag
    function automatic commit_pkg::rob_entry_t expected_rob_entry(
        input commit_pkg::instr_packet_t packet,
        input commit_pkg::data_word_t    value
    );
        commit_pkg::rob_entry_t entry;
        entry.result          = value;
        entry.reg_dest        = packet.reg_dest;
        entry.exception       = packet.exception;
        entry.exception_cause = packet.exception_cause;
        return entry;
    endfunction

    always #4 clk = ~clk;

    // The execution stage holds its results back while stall_o is high
    assign data_valid = want_valid & ~{`COMMIT_LANES{stall_out}};

    always_comb begin
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            exp_entry[i] = expected_rob_entry(ipacket[i], result[i]);
        end
    end

    commit_stage u_dut (
        .clk_i           ( clk           ),
        .rst_n_i         ( rst_n         ),
        .flush_i         ( flush         ),
        .stall_i         ( stall_in      ),
        .stall_o         ( stall_out     ),
        .data_valid_i    ( data_valid    ),
        .ipacket_i       ( ipacket       ),
        .result_i        ( result        ),
        .rob_write_o     ( rob_write     ),
        .rob_tag_o       ( rob_tag       ),
        .rob_entry_o     ( rob_entry     ),
        .buffers_empty_o ( buffers_empty )
    );

    commit_checker u_check (
        .clk_i           ( clk           ),
        .rst_n_i         ( rst_n         ),
        .flush_i         ( flush         ),
        .stall_i         ( stall_in      ),
        .dut_stall_i     ( stall_out     ),
        .data_valid_i    ( data_valid    ),
        .ipacket_i       ( ipacket       ),
        .exp_entry_i     ( exp_entry     ),
        .rob_write_i     ( rob_write     ),
        .rob_tag_i       ( rob_tag       ),
        .rob_entry_i     ( rob_entry     ),
        .buffers_empty_i ( buffers_empty ),
        .error_count_o   ( check_errors  ),
        .outstanding_o   ( outstanding   )
    );

    // ============================================================
    // Stimulus tasks
    // ============================================================

    task automatic drive_cycle(input logic [`COMMIT_LANES-1:0] valid, input logic stall,
                               input logic flush_now);
        commit_pkg::instr_packet_t [`COMMIT_LANES-1:0] pkts;
        commit_pkg::data_word_t    [`COMMIT_LANES-1:0] words;
        @(posedge clk);
        // Tags only advance once they were accepted at this edge, so none is reused early
        if (data_valid != '0) begin
            next_tag = next_tag + `COMMIT_TAG_W'(`COMMIT_LANES);
        end
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            rng = xorshift32(rng);
            pkts[i].rob_tag         = next_tag + `COMMIT_TAG_W'(i);
            pkts[i].reg_dest        = rng[`COMMIT_REG_W-1:0];
            pkts[i].exception       = (rng[15:12] == 4'd0);
            pkts[i].exception_cause = rng[11:8];
            rng = xorshift32(rng);
            words[i] = rng;
        end
        ipacket    <= pkts;
        result     <= words;
        want_valid <= valid;
        stall_in   <= stall;
        flush      <= flush_now;
    endtask

    // Stalls come in short bursts, a flush roughly once in 64 cycles
    task automatic random_cycle();
        logic [`COMMIT_LANES-1:0] valid;
        logic                     flush_now;
        rng = xorshift32(rng);
        valid     = rng[1:0];
        flush_now = (rng[13:8] == 6'd0);
        if (stall_left != 0) begin
            stall_left = stall_left - 1;
        end else if (rng[18:16] == 3'd0) begin
            stall_left = rng[22:20];
        end
        if (flush_now) begin
            valid = '0;
        end
        drive_cycle(valid, (stall_left != 0), flush_now);
    endtask

    // Inputs are idle here, so every accepted tag should reach the reorder buffer
    task automatic wait_for_drain(input string phase);
        int unsigned cycles;
        cycles = 0;
        @(negedge clk);
        while (!(buffers_empty && outstanding == 0) && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!buffers_empty) begin
            tb_errors++;
            $display("Timeout: buffers did not drain after the %s phase", phase);
        end else if (outstanding != 0) begin
            tb_errors++;
            $display("Timeout: %0d tags never written after the %s phase", outstanding, phase);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        stall_in   = 1'b0;
        want_valid = '0;
        ipacket    = '0;
        result     = '0;
        rng        = 32'd62614;
        next_tag   = '0;
        stall_left = 0;
        tb_errors  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Lone results into empty buffers bypass, one lane at a time
        drive_cycle(2'b01, 1'b0, 1'b0);
        drive_cycle(2'b10, 1'b0, 1'b0);
        drive_cycle(2'b00, 1'b0, 1'b0);
        wait_for_drain("bypass");
        // Both lanes in the same cycle
        drive_cycle(2'b11, 1'b0, 1'b0);
        drive_cycle(2'b00, 1'b0, 1'b0);
        wait_for_drain("simultaneous");
        // Long reorder buffer stall fills both buffers and raises stall_o
        repeat (12) drive_cycle(2'b11, 1'b1, 1'b0);
        drive_cycle(2'b00, 1'b0, 1'b0);
        wait_for_drain("stall");
        // Buffered results are dropped by a flush
        repeat (3) drive_cycle(2'b11, 1'b1, 1'b0);
        drive_cycle(2'b00, 1'b1, 1'b1);
        drive_cycle(2'b00, 1'b0, 1'b0);
        wait_for_drain("flush");

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            random_cycle();
        end
        drive_cycle(2'b00, 1'b0, 1'b0);
        wait_for_drain("random");

        @(negedge clk);
        $display("Errors: checker %0d, testbench %0d", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_commit_stage

`default_nettype wire

// File: verilog/commit_arbiter.sv
// Round-robin commit arbiter with bypass of fresh results to the reorder buffer
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commit_arbiter (
    input  wire logic                                        clk_i,
    input  wire logic                                        rst_n_i,
    input  wire logic                                        stall_i,

    // Fresh results from the execution lanes
    input  wire logic                  [`COMMIT_LANES-1:0]   lane_valid_i,
    input  wire commit_pkg::commit_item_t [`COMMIT_LANES-1:0] lane_item_i,

    // Heads and status of the commit buffers
    input  wire commit_pkg::commit_item_t [`COMMIT_LANES-1:0] buf_item_i,
    input  wire logic                  [`COMMIT_LANES-1:0]   buf_full_i,
    input  wire logic                  [`COMMIT_LANES-1:0]   buf_empty_i,

    // Buffer control
    output      logic                  [`COMMIT_LANES-1:0]   push_o,
    output      logic                  [`COMMIT_LANES-1:0]   pull_o,

    // Back-pressure to the execution stage
    output      logic                                        stall_o,

    // Reorder buffer write port
    output      logic                                        rob_write_o,
    output      logic                  [`COMMIT_TAG_W-1:0]   rob_tag_o,
    output      commit_pkg::rob_entry_t                      rob_entry_o
);

    // ============================================================
    // Turn register
    // ============================================================

    commit_pkg::turn_e turn_q;
    commit_pkg::turn_e turn_d;

    // Lane served first this cycle and the one behind it
    commit_pkg::lane_e own_lane;
    commit_pkg::lane_e other_lane;

    // Item that goes to the reorder buffer this cycle
    commit_pkg::commit_item_t sel_item;

    // The turn maps straight onto a lane index
    assign own_lane   = (turn_q == commit_pkg::TURN_LSU) ? commit_pkg::LANE_LSU
                                                         : commit_pkg::LANE_ITU;
    assign other_lane = (own_lane == commit_pkg::LANE_ITU) ? commit_pkg::LANE_LSU
                                                           : commit_pkg::LANE_ITU;

    // Hand the turn over only if the other buffer has something waiting
    always_comb begin
        turn_d = turn_q;
        if (!buf_empty_i[other_lane]) begin
            turn_d = (turn_q == commit_pkg::TURN_ITU) ? commit_pkg::TURN_LSU
                                                      : commit_pkg::TURN_ITU;
        end
    end

    // The turn holds while the reorder buffer stalls, a full buffer still gets its slot
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            turn_q <= commit_pkg::TURN_ITU;
        end else if (!stall_i) begin
            turn_q <= turn_d;
        end
    end

    // ============================================================
    // Push, pull and bypass selection
    // ============================================================

    always_comb begin
        // By default every valid result is parked in its own buffer
        push_o      = lane_valid_i;
        pull_o      = '0;
        rob_write_o = 1'b0;
        sel_item    = buf_item_i[own_lane];

        // Nothing leaves while the reorder buffer is stalled
        if (!stall_i) begin
            if (!buf_empty_i[own_lane]) begin
                // Drain the head, the new result of this lane queues behind it
                pull_o[own_lane] = 1'b1;
                rob_write_o      = 1'b1;
                sel_item         = buf_item_i[own_lane];
            end else if (lane_valid_i[own_lane]) begin
                // Own buffer is empty so its fresh result skips the buffer
                push_o[own_lane] = 1'b0;
                rob_write_o      = 1'b1;
                sel_item         = lane_item_i[own_lane];
            end else if (lane_valid_i[other_lane] && buf_empty_i[other_lane]) begin
                // Otherwise the other lane may use the idle slot if nothing of its own waits
                push_o[other_lane] = 1'b0;
                rob_write_o        = 1'b1;
                sel_item           = lane_item_i[other_lane];
            end
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    // Any full buffer holds the execution stage
    assign stall_o = |buf_full_i;

    // Tag goes on its own port, the rest forms the stored entry
    assign rob_tag_o   = sel_item.packet.rob_tag;
    assign rob_entry_o = commit_pkg::build_rob_entry(sel_item.packet, sel_item.result);

endmodule : commit_arbiter

`default_nettype wire

// File: verilog/commit_buffer.sv
// Per-lane commit buffer, a first-word-fall-through circular FIFO
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commit_buffer #(
    parameter int unsigned DEPTH  = `COMMIT_BUF_DEPTH,
    parameter type         ITEM_T = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    input  wire logic  flush_i,

    // Write and read strobes from the arbiter
    input  wire logic  push_i,
    input  wire logic  pull_i,

    // Incoming item and current head
    input  wire ITEM_T item_i,
    output      ITEM_T item_o,

    // Status decoded from the registered count
    output      logic  full_o,
    output      logic  empty_o
);

    // ============================================================
    // Local sizing
    // ============================================================

    // A single-entry buffer still needs a one-bit pointer
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // The count must be able to hold DEPTH itself
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // ============================================================
    // Storage and pointers
    // ============================================================

    ITEM_T             mem_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;

    // Pointers walk the array and wrap after the last slot
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Data is written at the tail, a flush throws the new item away
    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr_q] <= item_i;
        end
    end

    // Control state, flush empties the buffer just like reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pull_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end

            // A simultaneous push and pull leaves the occupancy as it is
            case ({push_i, pull_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    // Head is visible in the same cycle it is pulled
    assign item_o = mem_q[rd_ptr_q];

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

endmodule : commit_buffer

`default_nettype wire

// File: verilog/commit_macros.svh
// Commit stage widths, lane count and default buffer depth

`ifndef COMMIT_MACROS_SVH
`define COMMIT_MACROS_SVH

// Width of one execution result
`define COMMIT_XLEN 32

// Architectural register address width
`define COMMIT_REG_W 5

// Reorder buffer tag width, one tag per in-flight instruction
`define COMMIT_TAG_W 6

// Exception cause code width
`define COMMIT_CAUSE_W 4

// Lane 0 is the integer unit, lane 1 the load/store unit
`define COMMIT_LANES 2

// Entries in each lane's commit buffer
`define COMMIT_BUF_DEPTH 4

`endif

// File: verilog/commit_pkg.sv
// Commit stage types and the reorder buffer entry builder
`default_nettype none

`include "commit_macros.svh"

package commit_pkg;

    // One execution result
    typedef logic [`COMMIT_XLEN-1:0] data_word_t;

    // Packet that follows an instruction through the execution lanes (16 bits)
    typedef struct packed {
        logic [`COMMIT_TAG_W-1:0]   rob_tag;
        logic [`COMMIT_REG_W-1:0]   reg_dest;
        logic                       exception;
        logic [`COMMIT_CAUSE_W-1:0] exception_cause;
    } instr_packet_t;

    // What a commit buffer holds, packet on top of the result (48 bits)
    typedef struct packed {
        instr_packet_t packet;
        data_word_t    result;
    } commit_item_t;

    // Reorder buffer payload, the tag goes on its own port (42 bits)
    typedef struct packed {
        data_word_t                 result;
        logic [`COMMIT_REG_W-1:0]   reg_dest;
        logic                       exception;
        logic [`COMMIT_CAUSE_W-1:0] exception_cause;
    } rob_entry_t;

    // Lane index into the per-lane port arrays
    typedef enum logic {
        LANE_ITU = 1'b0,
        LANE_LSU = 1'b1
    } lane_e;

    // Which buffer the arbiter serves first
    typedef enum logic {
        TURN_ITU = 1'b0,
        TURN_LSU = 1'b1
    } turn_e;

    // Strip the tag and keep what the reorder buffer stores
    function automatic rob_entry_t build_rob_entry(input instr_packet_t packet,
                                                   input data_word_t    result);
        rob_entry_t entry;
        entry.result          = result;
        entry.reg_dest        = packet.reg_dest;
        entry.exception       = packet.exception;
        entry.exception_cause = packet.exception_cause;
        return entry;
    endfunction

endpackage : commit_pkg

`default_nettype wire

// File: verilog/commit_stage.sv
// Commit stage top, two lane buffers feeding the reorder buffer through one arbiter
`timescale 1ns/1ps
`default_nettype none

`include "commit_macros.svh"

module commit_stage (
    input  wire logic                                          clk_i,
    input  wire logic                                          rst_n_i,
    input  wire logic                                          flush_i,
    input  wire logic                                          stall_i,
    output      logic                                          stall_o,

    // Execution lanes, index 0 is the ITU and index 1 the LSU
    input  wire logic                    [`COMMIT_LANES-1:0]   data_valid_i,
    input  wire commit_pkg::instr_packet_t [`COMMIT_LANES-1:0] ipacket_i,
    input  wire commit_pkg::data_word_t  [`COMMIT_LANES-1:0]   result_i,

    // Reorder buffer write port
    output      logic                                          rob_write_o,
    output      logic                    [`COMMIT_TAG_W-1:0]   rob_tag_o,
    output      commit_pkg::rob_entry_t                        rob_entry_o,

    // High when nothing is waiting in either buffer
    output      logic                                          buffers_empty_o
);

    // ============================================================
    // Nets
    // ============================================================

    // Packet and result of each lane joined into one item
    commit_pkg::commit_item_t [`COMMIT_LANES-1:0] lane_item;

    // Buffer heads and status
    commit_pkg::commit_item_t [`COMMIT_LANES-1:0] buf_item;
    logic                     [`COMMIT_LANES-1:0] buf_full;
    logic                     [`COMMIT_LANES-1:0] buf_empty;

    // Buffer control from the arbiter
    logic                     [`COMMIT_LANES-1:0] buf_push;
    logic                     [`COMMIT_LANES-1:0] buf_pull;

    always_comb begin
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            lane_item[i].packet = ipacket_i[i];
            lane_item[i].result = result_i[i];
        end
    end

    // ============================================================
    // Lane buffers
    // ============================================================

    // Integer unit results
    commit_buffer #(
        .DEPTH  ( `COMMIT_BUF_DEPTH         ),
        .ITEM_T ( commit_pkg::commit_item_t )
    ) u_itu_buffer (
        .clk_i   ( clk_i                          ),
        .rst_n_i ( rst_n_i                        ),
        .flush_i ( flush_i                        ),
        .push_i  ( buf_push[commit_pkg::LANE_ITU] ),
        .pull_i  ( buf_pull[commit_pkg::LANE_ITU] ),
        .item_i  ( lane_item[commit_pkg::LANE_ITU] ),
        .item_o  ( buf_item[commit_pkg::LANE_ITU] ),
        .full_o  ( buf_full[commit_pkg::LANE_ITU] ),
        .empty_o ( buf_empty[commit_pkg::LANE_ITU] )
    );

    // Load/store results, latency varies with memory
    commit_buffer #(
        .DEPTH  ( `COMMIT_BUF_DEPTH         ),
        .ITEM_T ( commit_pkg::commit_item_t )
    ) u_lsu_buffer (
        .clk_i   ( clk_i                          ),
        .rst_n_i ( rst_n_i                        ),
        .flush_i ( flush_i                        ),
        .push_i  ( buf_push[commit_pkg::LANE_LSU] ),
        .pull_i  ( buf_pull[commit_pkg::LANE_LSU] ),
        .item_i  ( lane_item[commit_pkg::LANE_LSU] ),
        .item_o  ( buf_item[commit_pkg::LANE_LSU] ),
        .full_o  ( buf_full[commit_pkg::LANE_LSU] ),
        .empty_o ( buf_empty[commit_pkg::LANE_LSU] )
    );

    // ============================================================
    // Arbiter
    // ============================================================

    commit_arbiter u_arbiter (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .stall_i      ( stall_i      ),
        .lane_valid_i ( data_valid_i ),
        .lane_item_i  ( lane_item    ),
        .buf_item_i   ( buf_item     ),
        .buf_full_i   ( buf_full     ),
        .buf_empty_i  ( buf_empty    ),
        .push_o       ( buf_push     ),
        .pull_o       ( buf_pull     ),
        .stall_o      ( stall_o      ),
        .rob_write_o  ( rob_write_o  ),
        .rob_tag_o    ( rob_tag_o    ),
        .rob_entry_o  ( rob_entry_o  )
    );

    // Both buffers drained
    assign buffers_empty_o = buf_empty[commit_pkg::LANE_ITU] & buf_empty[commit_pkg::LANE_LSU];

endmodule : commit_stage

`default_nettype wire
